// ==== csSelectPkg.sv ====
`default_nettype none

package csSelectPkg;

  localparam int CsWordWidth  = 32;  // One microcode control word
  localparam int NumPatterns  = 24;  // Entries in the opcode table and in the store
  localparam int IndexWidth   = 5;   // Enough bits to address NumPatterns entries
  localparam int AxiAddrWidth = 8;   // Byte address on the host bus
  localparam int AxiDataWidth = 32;  // Host data matches the control word width

  localparam logic [1:0] RespOkay   = 2'b00;  // Normal completion
  localparam logic [1:0] RespSlvErr = 2'b10;  // Address beyond the store

  typedef logic [CsWordWidth-1:0] csWordT;
  typedef logic [IndexWidth-1:0]  opIndexT;

  // One opcode pattern as seen by the first decode stage
  typedef struct packed {
    logic [7:0] opByte;   // Opcode byte to compare
    logic [2:0] lowMask;  // Set bits are don't care for the +r forms
    logic       twoByte;  // Needs a 0F escape in B1 and compares B2
    logic       useReg;   // Compares the ModRM reg field in B2
    logic [2:0] regVal;   // Expected reg field when useReg is set
  } opPatternT;

  // Order matters because the lowest matching index wins
  localparam opPatternT PatternTable [NumPatterns] = '{
    '{8'h01, 3'b000, 1'b0, 1'b0, 3'd0},  // ADD r/m32, r32
    '{8'h03, 3'b000, 1'b0, 1'b0, 3'd0},  // ADD r32, r/m32
    '{8'h05, 3'b000, 1'b0, 1'b0, 3'd0},  // ADD EAX, imm32
    '{8'h80, 3'b000, 1'b0, 1'b1, 3'd0},  // ADD r/m8, imm8 as 80 /0
    '{8'h81, 3'b000, 1'b0, 1'b1, 3'd0},  // ADD r/m32, imm32 as 81 /0
    '{8'h83, 3'b000, 1'b0, 1'b1, 3'd0},  // ADD r/m32, imm8 as 83 /0
    '{8'h21, 3'b000, 1'b0, 1'b0, 3'd0},  // AND r/m32, r32
    '{8'h81, 3'b000, 1'b0, 1'b1, 3'd4},  // AND r/m32, imm32 as 81 /4
    '{8'h09, 3'b000, 1'b0, 1'b0, 3'd0},  // OR r/m32, r32
    '{8'h81, 3'b000, 1'b0, 1'b1, 3'd1},  // OR r/m32, imm32 as 81 /1
    '{8'hC0, 3'b000, 1'b0, 1'b0, 3'd0},  // SAL r/m8, imm8 which shadows the SAR entry
    '{8'hC0, 3'b000, 1'b0, 1'b0, 3'd0},  // SAR r/m8, imm8 never wins
    '{8'h89, 3'b000, 1'b0, 1'b0, 3'd0},  // MOV r/m32, r32
    '{8'h8B, 3'b000, 1'b0, 1'b0, 3'd0},  // MOV r32, r/m32
    '{8'hB8, 3'b111, 1'b0, 1'b0, 3'd0},  // MOV r32, imm32 for B8 to BF
    '{8'h50, 3'b111, 1'b0, 1'b0, 3'd0},  // PUSH r32 for 50 to 57
    '{8'h58, 3'b111, 1'b0, 1'b0, 3'd0},  // POP r32 for 58 to 5F
    '{8'hFF, 3'b000, 1'b0, 1'b1, 3'd6},  // PUSH r/m32 as FF /6
    '{8'hEB, 3'b000, 1'b0, 1'b0, 3'd0},  // JMP rel8
    '{8'hE9, 3'b000, 1'b0, 1'b0, 3'd0},  // JMP rel32
    '{8'h75, 3'b000, 1'b0, 1'b0, 3'd0},  // JNE rel8
    '{8'h85, 3'b000, 1'b1, 1'b0, 3'd0},  // JNE rel32 as 0F 85
    '{8'hE8, 3'b000, 1'b0, 1'b0, 3'd0},  // CALL rel32 near
    '{8'hC3, 3'b000, 1'b0, 1'b0, 3'd0}   // RET near
  };

endpackage

`default_nettype wire

// ==== opcodeMatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcodeMatcher (
  input  logic [7:0]           b1,          // First instruction byte
  input  logic [7:0]           b2,          // Second byte or ModRM
  output csSelectPkg::opIndexT matchIndex,  // Lowest matching table entry
  output logic                 matchHit     // Any entry matched
);
  import csSelectPkg::*;

  logic [NumPatterns-1:0] patHit;  // One match flag per table entry

  for (genvar i = 0; i < NumPatterns; i++) begin : gPat
    localparam opPatternT Pat = PatternTable[i];

    logic [7:0] cmpByte;   // Byte that carries the opcode for this entry
    logic       byteOk;
    logic       prefixOk;
    logic       regOk;

    assign cmpByte  = Pat.twoByte ? b2 : b1;  // Escaped opcodes sit in B2
    assign prefixOk = !Pat.twoByte || (b1 == 8'h0F);  // Two-byte forms need the 0F escape
    // Masked low bits carry the register number of the +r forms
    assign byteOk   = ((cmpByte ^ Pat.opByte) & ~{5'b00000, Pat.lowMask}) == 8'h00;
    assign regOk    = !Pat.useReg || (b2[5:3] == Pat.regVal);  // ModRM reg field extension

    assign patHit[i] = prefixOk && byteOk && regOk;
  end

  // Priority encoder that walks downward so the lowest index is left standing
  always_comb begin
    matchIndex = '0;  // Index is a don't care on a miss
    for (int i = NumPatterns - 1; i >= 0; i--) begin
      if (patHit[i]) begin
        matchIndex = opIndexT'(i);
      end
    end
  end

  assign matchHit = |patHit;  // Miss when no entry fires

endmodule

`default_nettype wire

// ==== controlStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlStore (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 wrEn,     // Host write strobe
  input  csSelectPkg::opIndexT wrIndex,  // Always inside the table when wrEn is high
  input  csSelectPkg::csWordT  wrWord,
  input  csSelectPkg::opIndexT rdIndex,  // Shared between decode and host reads
  output csSelectPkg::csWordT  rdWord    // Registered read data
);
  import csSelectPkg::*;

  csWordT mem [NumPatterns];  // One control word per opcode pattern

  // Store comes up all zeros so an unloaded entry decodes to a null word
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumPatterns; i++) begin
        mem[i] <= '0;
      end
    end else if (wrEn) begin
      mem[wrIndex] <= wrWord;  // Whole word written regardless of strobes
    end
  end

  // One cycle read so a write in the same cycle leaves the old word on rdWord
  always_ff @(posedge clk) begin
    if (rdIndex < opIndexT'(NumPatterns)) begin
      rdWord <= mem[rdIndex];
    end else begin
      rdWord <= '0;  // Indices past the table read as zero
    end
  end

endmodule

`default_nettype wire

// ==== csAxiCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csAxiCtrl (
  input  logic                                  clk,
  input  logic                                  arstN,
  input  logic                                  decValid,    // Decode request this cycle
  input  csSelectPkg::opIndexT                  matchIndex,  // From the opcode matcher
  input  logic                                  matchHit,
  input  csSelectPkg::csWordT                   rdWord,      // Store read data
  input  logic [csSelectPkg::AxiAddrWidth-1:0]  awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [csSelectPkg::AxiDataWidth-1:0]  wdata,
  input  logic [csSelectPkg::AxiDataWidth/8-1:0] wstrb,      // Accepted and not used
  input  logic                                  wvalid,
  output logic                                  wready,
  output logic [1:0]                            bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  input  logic [csSelectPkg::AxiAddrWidth-1:0]  araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  output logic [csSelectPkg::AxiDataWidth-1:0]  rdata,
  output logic [1:0]                            rresp,
  output logic                                  rvalid,
  input  logic                                  rready,
  output logic                                  wrEn,
  output csSelectPkg::opIndexT                  wrIndex,
  output csSelectPkg::csWordT                   wrWord,
  output csSelectPkg::opIndexT                  rdIndex,
  output logic                                  outValid,
  output logic                                  hit,
  output csSelectPkg::csWordT                   csWord
);
  import csSelectPkg::*;

  typedef enum logic [1:0] {WrIdle, WrAccept, WrResp} wrStateT;
  typedef enum logic [2:0] {RdIdle, RdAccept, RdPort, RdCapture, RdResp} rdStateT;

  wrStateT wrState;
  rdStateT rdState;
  logic    s1Valid;    // Decode stage 1 holds a request
  logic    s1Hit;
  opIndexT s1Index;    // Drives the store read port while s1Valid is high
  logic    s2Valid;    // Store word for stage 1 is on rdWord
  logic    s2Hit;
  opIndexT rdAddrIdx;  // Word index of the accepted host read
  logic    awInRange;
  logic    arInRange;

  // Word index is the byte address without its two low bits
  assign awInRange = int'(awaddr[AxiAddrWidth-1:2]) < NumPatterns;
  assign arInRange = int'(araddr[AxiAddrWidth-1:2]) < NumPatterns;

  // Decode pipeline with no back-pressure
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
      s1Hit   <= 1'b0;
      s2Valid <= 1'b0;
      s2Hit   <= 1'b0;
    end else begin
      s1Valid <= decValid;
      s1Hit   <= decValid && matchHit;  // Hit only travels with a live request
      s2Valid <= s1Valid;
      s2Hit   <= s1Hit;
    end
  end

  always_ff @(posedge clk) begin
    s1Index <= matchIndex;
  end

  assign outValid = s2Valid;
  assign hit      = s2Hit;
  assign csWord   = s2Hit ? rdWord : '0;  // Miss yields an all zero word

  // Decode owns the read port and the host read waits for a free cycle
  assign rdIndex = s1Valid ? s1Index : rdAddrIdx;

  // Write path takes address and data together and answers one cycle later
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrState <= WrIdle;
    end else begin
      case (wrState)
        WrIdle: begin
          if (awvalid && wvalid) begin
            wrState <= WrAccept;
          end
        end
        WrAccept: wrState <= WrResp;  // Both valids are held so the handshake completes here
        WrResp: begin
          if (bready) begin
            wrState <= WrIdle;
          end
        end
        default: wrState <= WrIdle;
      endcase
    end
  end

  assign awready = wrState == WrAccept;
  assign wready  = wrState == WrAccept;
  assign bvalid  = wrState == WrResp;
  assign wrEn    = (wrState == WrAccept) && awInRange;  // Out of range writes are dropped
  assign wrIndex = awaddr[2 +: IndexWidth];
  assign wrWord  = wdata;

  // Read path with a variable wait for the shared store port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdState <= RdIdle;
    end else begin
      case (rdState)
        RdIdle: begin
          if (arvalid) begin
            rdState <= RdAccept;
          end
        end
        RdAccept: begin
          if (arvalid) begin
            rdState <= arInRange ? RdPort : RdResp;  // Bad address skips the store
          end
        end
        RdPort: begin
          if (!s1Valid) begin
            rdState <= RdCapture;  // Port is ours in this cycle
          end
        end
        RdCapture: rdState <= RdResp;
        RdResp: begin
          if (rready) begin
            rdState <= RdIdle;
          end
        end
        default: rdState <= RdIdle;
      endcase
    end
  end

  assign arready = rdState == RdAccept;
  assign rvalid  = rdState == RdResp;

  // Response payloads stay put while the host holds off
  always_ff @(posedge clk) begin
    if (rdState == RdAccept) begin
      rdAddrIdx <= araddr[2 +: IndexWidth];
      rdata     <= '0;  // Stays zero for an SLVERR read
      rresp     <= arInRange ? RespOkay : RespSlvErr;
    end
    if (rdState == RdCapture) begin
      rdata <= rdWord;  // Word fetched in the RdPort cycle
    end
    if (wrState == WrAccept) begin
      bresp <= awInRange ? RespOkay : RespSlvErr;
    end
  end

endmodule

`default_nettype wire

// ==== csSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module csSelect (
  input  logic                                   clk,
  input  logic                                   arstN,
  input  logic                                   decValid,  // One decode request per cycle at most
  input  logic [7:0]                             b1,
  input  logic [7:0]                             b2,
  output logic                                   outValid,  // Two cycles after decValid
  output logic                                   hit,
  output csSelectPkg::csWordT                    csWord,
  input  logic [csSelectPkg::AxiAddrWidth-1:0]   awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [csSelectPkg::AxiDataWidth-1:0]   wdata,
  input  logic [csSelectPkg::AxiDataWidth/8-1:0] wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [csSelectPkg::AxiAddrWidth-1:0]   araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [csSelectPkg::AxiDataWidth-1:0]   rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready
);
  import csSelectPkg::*;

  opIndexT matchIndex;  // Combinational matcher result
  logic    matchHit;
  logic    wrEn;        // Host write into the store
  opIndexT wrIndex;
  csWordT  wrWord;
  opIndexT rdIndex;     // Shared read port address
  csWordT  rdWord;

  opcodeMatcher opcodeMatcher_i (
    .b1         (b1),
    .b2         (b2),
    .matchIndex (matchIndex),
    .matchHit   (matchHit)
  );

  controlStore controlStore_i (
    .clk     (clk),
    .arstN   (arstN),
    .wrEn    (wrEn),
    .wrIndex (wrIndex),
    .wrWord  (wrWord),
    .rdIndex (rdIndex),
    .rdWord  (rdWord)
  );

  csAxiCtrl csAxiCtrl_i (
    .clk        (clk),
    .arstN      (arstN),
    .decValid   (decValid),
    .matchIndex (matchIndex),
    .matchHit   (matchHit),
    .rdWord     (rdWord),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .wrEn       (wrEn),
    .wrIndex    (wrIndex),
    .wrWord     (wrWord),
    .rdIndex    (rdIndex),
    .outValid   (outValid),
    .hit        (hit),
    .csWord     (csWord)
  );

endmodule

`default_nettype wire

// ==== csSelect_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module csSelect_asserts (
  input logic                                 clk,
  input logic                                 arstN,
  input logic                                 decValid,
  input logic                                 outValid,
  input logic                                 awvalid,
  input logic                                 awready,
  input logic                                 wvalid,
  input logic                                 wready,
  input logic [csSelectPkg::AxiAddrWidth-1:0] awaddr,
  input logic                                 bvalid,
  input logic                                 bready,
  input logic                                 arvalid,
  input logic                                 arready,
  input logic [csSelectPkg::AxiAddrWidth-1:0] araddr,
  input logic                                 rvalid,
  input logic                                 rready,
  input logic [csSelectPkg::AxiDataWidth-1:0] rdata
);

  // A write is offered on both channels at once and held until taken
  assert property (@(posedge clk) disable iff (!arstN)
    ((awvalid && !awready) || (wvalid && !wready)) |=> awvalid && wvalid && $stable(awaddr))
    else $error("Write valid or address changed before the handshake");
  assert property (@(posedge clk) disable iff (!arstN)
    arvalid && !arready |=> arvalid && $stable(araddr))  // Read address held by the host
    else $error("Read valid or address changed before the handshake");
  assert property (@(posedge clk) disable iff (!arstN)
    bvalid && !bready |=> bvalid)  // Write response survives back-pressure
    else $error("Write response dropped while bready was low");
  assert property (@(posedge clk) disable iff (!arstN)
    rvalid && !rready |=> rvalid && $stable(rdata))  // Read data frozen under back-pressure
    else $error("Read response dropped or changed while rready was low");
  assert property (@(posedge clk) disable iff (!arstN) outValid == $past(decValid, 2))
    else $error("outValid does not follow decValid by two cycles");
  assert property (@(posedge clk)
    !arstN |-> !outValid && !bvalid && !rvalid && !awready && !wready && !arready)
    else $error("A control output is high during reset");

endmodule

`default_nettype wire

// ==== csSelectTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csSelectTb;
  import csSelectPkg::*;

  localparam int     CycleLimit = 4000;          // The tests need about 1500 cycles
  localparam csWordT SalWord    = 32'h5A10_C004;  // Entry 10 which must win for C0
  localparam csWordT SarWord    = 32'h5A11_C007;  // Entry 11 which is shadowed

  typedef struct packed {
    int unsigned cycle;  // Monitor cycle in which decValid was seen
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic        hit;    // Filled in one cycle later when the store is read
    csWordT      word;
  } decReqT;

  logic                      clk;
  logic                      arstN;
  logic                      decValid;
  logic [7:0]                b1;
  logic [7:0]                b2;
  logic                      outValid;
  logic                      hit;
  csWordT                    csWord;
  logic [AxiAddrWidth-1:0]   awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [AxiDataWidth-1:0]   wdata;
  logic [AxiDataWidth/8-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  logic [AxiAddrWidth-1:0]   araddr;
  logic                      arvalid;
  logic                      arready;
  logic [AxiDataWidth-1:0]   rdata;
  logic [1:0]                rresp;
  logic                      rvalid;
  logic                      rready;

  csWordT      model [NumPatterns] = '{default: '0};  // Mirror of the store, cleared like it
  decReqT      pending [$];                           // Requests waiting for their result
  int unsigned obsCycle   = 0;
  int unsigned cycleCount = 0;

  csSelect csSelect_i (.*);

  bind csAxiCtrl csSelect_asserts csSelect_asserts_i (.*);

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input csWordT expVal, input csWordT actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("** Error at %0t ns: %s expected %h, got %h",
                            $time, name, expVal, actVal));
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("** Error at %0t ns: %s expected %b, got %b",
                            $time, name, expVal, actVal));
    end
  endtask

  task automatic checkResp(input string name, input logic [1:0] expVal, input logic [1:0] actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("** Error at %0t ns: %s expected %b, got %b",
                            $time, name, expVal, actVal));
    end
  endtask

  // First table entry whose byte, escape and reg field all agree with the request
  function automatic logic refDecode(input logic [7:0] x1, input logic [7:0] x2,
                                     output opIndexT idx);
    opPatternT  pat;
    logic [7:0] opb;
    logic [7:0] care;
    logic       found;
    found = 1'b0;
    idx   = '0;
    for (int i = 0; i < NumPatterns; i++) begin
      pat  = PatternTable[opIndexT'(i)];
      opb  = pat.twoByte ? x2 : x1;       // Escaped opcodes are in the second byte
      care = ~{5'b00000, pat.lowMask};    // Register bits of +r forms are free
      if (!found && (!pat.twoByte || x1 == 8'h0F) && (opb & care) == (pat.opByte & care)
          && (!pat.useReg || x2[5:3] == pat.regVal)) begin
        found = 1'b1;
        idx   = opIndexT'(i);
      end
    end
    return found;
  endfunction

  task automatic axiWrite(input logic [AxiAddrWidth-1:0] addr, input csWordT data,
                          output logic [1:0] resp);
    logic done;
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'($urandom());  // Strobes do not matter to the store
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      done = awready && wready;  // Seen before the edge that takes it
      @(posedge clk);
      #1;
    end while (!done);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat ($urandom_range(7)) @(posedge clk);  // Response held off for a while
    #1;
    bready = 1'b1;
    do begin
      done = bvalid && bready;
      resp = bresp;
      @(posedge clk);
      #1;
    end while (!done);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [AxiAddrWidth-1:0] addr, output csWordT data,
                         output logic [1:0] resp);
    logic done;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      done = arready;
      @(posedge clk);
      #1;
    end while (!done);
    arvalid = 1'b0;
    repeat ($urandom_range(7)) @(posedge clk);
    #1;
    rready = 1'b1;
    do begin
      done = rvalid && rready;  // Latency varies with decode traffic on the read port
      data = rdata;
      resp = rresp;
      @(posedge clk);
      #1;
    end while (!done);
    rready = 1'b0;
  endtask

  // Word idx lives at byte address 4 * idx
  task automatic writeCheck(input int idx, input csWordT data);
    logic [1:0] resp;
    axiWrite(8'(4 * idx), data, resp);
    checkResp("bresp", idx < NumPatterns ? RespOkay : RespSlvErr, resp);
  endtask

  task automatic readCheck(input int idx);
    csWordT     word;
    logic [1:0] resp;
    axiRead(8'(4 * idx), word, resp);
    if (idx < NumPatterns) begin
      checkResp("rresp", RespOkay, resp);
      checkWord("rdata", model[idx], word);
    end else begin
      checkResp("rresp", RespSlvErr, resp);  // Index beyond the store errors
      checkWord("rdata", '0, word);
    end
  endtask

  // Mix of misses, +r registers, exact reg fields and 0F escapes
  task automatic pickBytes(output logic [7:0] x1, output logic [7:0] x2);
    opPatternT pat;
    pat = PatternTable[opIndexT'($urandom_range(NumPatterns - 1))];
    x2  = 8'($urandom());
    case ($urandom_range(3))
      0: x1 = 8'($urandom());
      1: x1 = pat.opByte | (8'($urandom()) & {5'b00000, pat.lowMask});
      2: begin
        x1 = pat.twoByte ? 8'h0F : pat.opByte;
        x2 = pat.twoByte ? pat.opByte : {x2[7:6], pat.regVal, x2[2:0]};
      end
      default: x1 = 8'h0F;  // Escape with a mostly unknown second byte
    endcase
  endtask

  task automatic decodeTraffic(input int cycles, input int density);
    logic [7:0] x1;
    logic [7:0] x2;
    for (int i = 0; i < cycles; i++) begin
      pickBytes(x1, x2);
      @(posedge clk);
      #1;
      decValid = int'($urandom_range(99)) < density;
      b1       = x1;
      b2       = x2;
    end
    @(posedge clk);
    #1;
    decValid = 1'b0;
  endtask

  task automatic decodeOne(input logic [7:0] x1, input logic [7:0] x2, input csWordT expWord);
    int waitCycles;
    @(posedge clk);
    #1;
    decValid = 1'b1;
    b1       = x1;
    b2       = x2;
    @(posedge clk);
    #1;
    decValid   = 1'b0;
    waitCycles = 0;
    while (!outValid) begin
      @(posedge clk);
      #1;
      waitCycles++;
      if (waitCycles > 4) stopOnError("No decode result came back for a single request");
    end
    checkBit("hit", 1'b1, hit);
    checkWord("csWord", expWord, csWord);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount >= CycleLimit) stopOnError("Timeout before all tests finished");
    end
  end

  // Mid-cycle view of what the coming rising edge will sample
  initial begin
    decReqT  rq;
    opIndexT idx;
    logic    due;
    forever begin
      @(negedge clk);
      if (arstN) begin
        due = pending.size() > 0 && pending[0].cycle + 2 == obsCycle;
        checkBit("outValid", due, outValid);
        if (due) begin
          rq = pending.pop_front();
          checkBit("hit", rq.hit, hit);
          checkWord("csWord", rq.word, csWord);
        end
        // Store is read for the previous request at the coming edge, before a write lands
        if (pending.size() > 0 && pending[pending.size() - 1].cycle + 1 == obsCycle) begin
          rq      = pending[pending.size() - 1];
          rq.hit  = refDecode(rq.b1, rq.b2, idx);
          rq.word = rq.hit ? model[idx] : '0;
          pending[pending.size() - 1] = rq;
        end
        if (awvalid && awready && wvalid && wready && int'(awaddr) / 4 < NumPatterns) begin
          model[int'(awaddr) / 4] = wdata;
        end
        if (decValid) pending.push_back('{obsCycle, b1, b2, 1'b0, '0});
        obsCycle++;
      end
    end
  end

  initial begin
    void'($urandom(83445));
    arstN    = 1'b1;
    decValid = 1'b0;
    b1       = '0;
    b2       = '0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    #10 arstN = 1'b0;  // Falling edge clears the store
    repeat (4) @(posedge clk);
    #1 arstN = 1'b1;
    for (int i = 0; i < NumPatterns; i++) writeCheck(i, $urandom());
    for (int i = 0; i < NumPatterns; i++) readCheck(i);
    for (int i = NumPatterns; i < 64; i += 13) begin
      writeCheck(i, $urandom());  // Must be dropped with SLVERR
      readCheck(i);
    end
    for (int i = 0; i < NumPatterns; i++) readCheck(i);
    decodeTraffic(300, 100);
    writeCheck(10, SalWord);
    writeCheck(11, SarWord);
    decodeOne(8'hC0, 8'hE0, SalWord);  // Reg field 4
    decodeOne(8'hC0, 8'hF8, SalWord);  // Reg field 7
    fork
      decodeTraffic(400, 70);
      for (int i = 0; i < 40; i++) begin
        if ($urandom_range(2) == 0) writeCheck($urandom_range(31), $urandom());
        else readCheck($urandom_range(31));
      end
    join
    repeat (3) @(posedge clk);  // Last decode results still drain through the monitor
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== csSelect.f ====
csSelectPkg.sv
opcodeMatcher.sv
controlStore.sv
csAxiCtrl.sv
csSelect.sv
csSelect_asserts.sv
csSelectTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the csSelect testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module csSelectTb -f csSelect.f -o simCsSelect
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/simCsSelect
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
